// ==== hdl/memcopy_pkg.sv ====
/*
 * Shared widths, register offsets, window decoding and status bits
 * of the memory-copy peripheral
 */
`default_nettype none

package memcopy_pkg;

  // Data path and memory geometry
  localparam int DATA_W    = 32;
  localparam int MEM_WORDS = 128;
  localparam int WADDR_W   = 7;

  // APB byte address width
  localparam int APB_ADDR_W = 12;

  // Register byte offsets
  localparam logic [APB_ADDR_W-1:0] REG_SRC    = 12'h000;
  localparam logic [APB_ADDR_W-1:0] REG_DST    = 12'h004;
  localparam logic [APB_ADDR_W-1:0] REG_SIZE   = 12'h008;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS = 12'h00C;

  // Memory window select, word index sits in paddr[8:2]
  localparam int WIN_BIT = 9;

  // STATUS layout
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  // Word count register, larger counts wrap the indices
  localparam int SIZE_W = 8;

endpackage

`default_nettype wire

// ==== hdl/memcopy_regs.sv ====
/*
 * APB3 slave of the copy peripheral: SRC/DST/SIZE/STATUS registers,
 * memory window requests, busy error checks and the done interrupt
 */
`default_nettype none

module memcopy_regs (
  input  wire logic                               clk_i,
  input  wire logic                               arst_n_i,
  input  wire logic                               psel_i,
  input  wire logic                               penable_i,
  input  wire logic                               pwrite_i,
  input  wire logic [memcopy_pkg::APB_ADDR_W-1:0] paddr_i,
  input  wire logic [memcopy_pkg::DATA_W-1:0]     pwdata_i,
  output logic      [memcopy_pkg::DATA_W-1:0]     prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  input  wire logic                               busy_i,
  input  wire logic                               done_i,
  input  wire logic                               win_ack_i,
  input  wire logic [memcopy_pkg::DATA_W-1:0]     win_rdata_i,
  output logic                                    start_o,
  output logic      [memcopy_pkg::WADDR_W-1:0]    src_o,
  output logic      [memcopy_pkg::WADDR_W-1:0]    dst_o,
  output logic      [memcopy_pkg::SIZE_W-1:0]     size_o,
  output logic                                    win_req_o,
  output logic                                    win_we_o,
  output logic      [memcopy_pkg::WADDR_W-1:0]    win_addr_o,
  output logic      [memcopy_pkg::DATA_W-1:0]     win_wdata_o,
  output logic                                    intr_o
);

  logic                             access;
  logic                             is_win;
  logic                             sel_src;
  logic                             sel_dst;
  logic                             sel_size;
  logic                             sel_status;
  logic                             unmapped;
  logic                             err;
  logic                             wr_en;
  logic                             status_rd;
  logic [memcopy_pkg::WADDR_W-1:0]  src_q;
  logic [memcopy_pkg::WADDR_W-1:0]  dst_q;
  logic [memcopy_pkg::SIZE_W-1:0]   size_q;
  logic                             start_q;
  logic                             done_q;

  // Address decode
  assign access     = psel_i & penable_i;
  assign is_win     = paddr_i[memcopy_pkg::WIN_BIT];
  assign sel_src    = ~is_win & (paddr_i == memcopy_pkg::REG_SRC);
  assign sel_dst    = ~is_win & (paddr_i == memcopy_pkg::REG_DST);
  assign sel_size   = ~is_win & (paddr_i == memcopy_pkg::REG_SIZE);
  assign sel_status = ~is_win & (paddr_i == memcopy_pkg::REG_STATUS);
  assign unmapped   = ~is_win & ~(sel_src | sel_dst | sel_size | sel_status);

  // Config writes and window traffic are refused while a copy runs
  assign err = unmapped | (is_win & busy_i) |
               (pwrite_i & busy_i & (sel_src | sel_dst | sel_size));

  assign wr_en     = access & pwrite_i & ~err;
  assign status_rd = access & ~pwrite_i & sel_status;

  // Window transfers wait for the engine, everything else is zero wait
  assign pready_o  = access & (~is_win | err | win_ack_i);
  assign pslverr_o = access & err;

  assign win_req_o   = access & is_win & ~err;
  assign win_we_o    = pwrite_i;
  assign win_addr_o  = paddr_i[memcopy_pkg::WIN_BIT-1 -: memcopy_pkg::WADDR_W];
  assign win_wdata_o = pwdata_i;

  always_comb begin
    prdata_o = '0;
    if (is_win) begin
      prdata_o = win_rdata_i;
    end else if (sel_src) begin
      prdata_o[memcopy_pkg::WADDR_W-1:0] = src_q;
    end else if (sel_dst) begin
      prdata_o[memcopy_pkg::WADDR_W-1:0] = dst_q;
    end else if (sel_size) begin
      prdata_o[memcopy_pkg::SIZE_W-1:0] = size_q;
    end else if (sel_status) begin
      prdata_o[memcopy_pkg::STATUS_BUSY_BIT] = busy_i;
      prdata_o[memcopy_pkg::STATUS_DONE_BIT] = done_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      size_q  <= '0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      if (wr_en && sel_src) begin
        src_q <= pwdata_i[memcopy_pkg::WADDR_W-1:0];
      end
      if (wr_en && sel_dst) begin
        dst_q <= pwdata_i[memcopy_pkg::WADDR_W-1:0];
      end
      if (wr_en && sel_size) begin
        size_q <= pwdata_i[memcopy_pkg::SIZE_W-1:0];
      end
      // Start one cycle later so the engine sees the new count
      start_q <= wr_en & sel_size;
      // A new done wins over a STATUS read in the same cycle
      if (done_i) begin
        done_q <= 1'b1;
      end else if (status_rd) begin
        done_q <= 1'b0;
      end
    end
  end

  assign start_o = start_q;
  assign src_o   = src_q;
  assign dst_o   = dst_q;
  assign size_o  = size_q;
  assign intr_o  = done_q;

endmodule

`default_nettype wire

// ==== hdl/memcopy_engine.sv ====
/*
 * Copy engine FSM, owner of the OBI-style memory port
 * Forwards APB window accesses to memory while idle
 */
`default_nettype none

module memcopy_engine (
  input  wire logic                            clk_i,
  input  wire logic                            arst_n_i,
  input  wire logic                            start_i,
  input  wire logic [memcopy_pkg::WADDR_W-1:0] src_i,
  input  wire logic [memcopy_pkg::WADDR_W-1:0] dst_i,
  input  wire logic [memcopy_pkg::SIZE_W-1:0]  size_i,
  output logic                                 busy_o,
  output logic                                 done_o,
  input  wire logic                            win_req_i,
  input  wire logic                            win_we_i,
  input  wire logic [memcopy_pkg::WADDR_W-1:0] win_addr_i,
  input  wire logic [memcopy_pkg::DATA_W-1:0]  win_wdata_i,
  output logic                                 win_ack_o,
  output logic      [memcopy_pkg::DATA_W-1:0]  win_rdata_o,
  output logic                                 mem_req_o,
  output logic                                 mem_we_o,
  output logic      [memcopy_pkg::WADDR_W-1:0] mem_addr_o,
  output logic      [memcopy_pkg::DATA_W-1:0]  mem_wdata_o,
  input  wire logic                            mem_gnt_i,
  input  wire logic [memcopy_pkg::DATA_W-1:0]  mem_rdata_i,
  input  wire logic                            mem_rvalid_i
);

  typedef enum logic [1:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ
  } state_e;

  state_e                          state_q;
  logic [memcopy_pkg::SIZE_W-1:0]  cnt_q;
  logic [memcopy_pkg::WADDR_W-1:0] rd_idx_q;
  logic [memcopy_pkg::WADDR_W-1:0] wr_idx_q;
  logic [memcopy_pkg::DATA_W-1:0]  data_q;
  logic                            win_rd_pend_q;
  logic                            idle;
  logic                            last_wr;

  assign idle    = (state_q == IDLE);
  assign last_wr = (state_q == WR_REQ) & mem_gnt_i & (cnt_q == memcopy_pkg::SIZE_W'(1));

  assign busy_o = ~idle;
  // Size 0 finishes right away without touching memory
  assign done_o = (idle & start_i & (size_i == '0)) | last_wr;

  // Memory port mux
  always_comb begin
    mem_req_o   = 1'b0;
    mem_we_o    = 1'b0;
    mem_addr_o  = rd_idx_q;
    mem_wdata_o = data_q;
    case (state_q)
      IDLE: begin
        // Mask the request while a window read waits for rvalid
        mem_req_o   = win_req_i & ~win_rd_pend_q;
        mem_we_o    = win_we_i;
        mem_addr_o  = win_addr_i;
        mem_wdata_o = win_wdata_i;
      end
      RD_REQ: begin
        mem_req_o = 1'b1;
      end
      WR_REQ: begin
        mem_req_o  = 1'b1;
        mem_we_o   = 1'b1;
        mem_addr_o = wr_idx_q;
      end
      default: begin
      end
    endcase
  end

  assign win_ack_o   = idle & ((mem_req_o & win_we_i & mem_gnt_i) |
                               (win_rd_pend_q & mem_rvalid_i));
  assign win_rdata_o = mem_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= IDLE;
      cnt_q         <= '0;
      rd_idx_q      <= '0;
      wr_idx_q      <= '0;
      win_rd_pend_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            rd_idx_q <= src_i;
            wr_idx_q <= dst_i;
            cnt_q    <= size_i;
            if (size_i != '0) begin
              state_q <= RD_REQ;
            end
          end
          if (mem_req_o && !win_we_i && mem_gnt_i) begin
            win_rd_pend_q <= 1'b1;
          end else if (mem_rvalid_i) begin
            win_rd_pend_q <= 1'b0;
          end
        end
        RD_REQ: begin
          if (mem_gnt_i) begin
            rd_idx_q <= rd_idx_q + memcopy_pkg::WADDR_W'(1);
            state_q  <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (mem_rvalid_i) begin
            state_q <= WR_REQ;
          end
        end
        WR_REQ: begin
          if (mem_gnt_i) begin
            wr_idx_q <= wr_idx_q + memcopy_pkg::WADDR_W'(1);
            cnt_q    <= cnt_q - memcopy_pkg::SIZE_W'(1);
            state_q  <= last_wr ? IDLE : RD_REQ;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Word held between its read and its write
  always_ff @(posedge clk_i) begin
    if (state_q == RD_WAIT && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/slow_memory.sv ====
/*
 * Slow single-port RAM with an OBI-style req/gnt/rvalid port,
 * grant delay of 0..3 extra cycles drawn from an LFSR
 */
`default_nettype none

module slow_memory (
  input  wire logic                            clk_i,
  input  wire logic                            arst_n_i,
  input  wire logic                            req_i,
  input  wire logic                            we_i,
  input  wire logic [memcopy_pkg::WADDR_W-1:0] addr_i,
  input  wire logic [memcopy_pkg::DATA_W-1:0]  wdata_i,
  output logic                                 gnt_o,
  output logic      [memcopy_pkg::DATA_W-1:0]  rdata_o,
  output logic                                 rvalid_o
);

  logic [memcopy_pkg::DATA_W-1:0] mem_q [memcopy_pkg::MEM_WORDS];
  logic [15:0]                    lfsr_q;
  logic                           lfsr_fb;
  logic [1:0]                     dly_q;
  logic                           wait_q;
  logic                           rvalid_q;
  logic [memcopy_pkg::DATA_W-1:0] rdata_q;

  // x^16 + x^14 + x^13 + x^11
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  // Grant once the loaded delay has run out
  assign gnt_o = req_i & wait_q & (dly_q == 2'd0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q   <= 16'hace1;
      dly_q    <= 2'd0;
      wait_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o & ~we_i;
      if (gnt_o) begin
        wait_q <= 1'b0;
        lfsr_q <= {lfsr_q[14:0], lfsr_fb};
      end else if (req_i && !wait_q) begin
        // First cycle of a request, pick the delay
        wait_q <= 1'b1;
        dly_q  <= lfsr_q[1:0];
      end else if (wait_q) begin
        dly_q <= dly_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// ==== hdl/memcopy_subsystem.sv ====
/*
 * Memory-copy subsystem top: APB registers, copy engine, slow memory
 */
`default_nettype none

module memcopy_subsystem (
  input  wire logic                               clk_i,
  input  wire logic                               arst_n_i,
  input  wire logic                               psel_i,
  input  wire logic                               penable_i,
  input  wire logic                               pwrite_i,
  input  wire logic [memcopy_pkg::APB_ADDR_W-1:0] paddr_i,
  input  wire logic [memcopy_pkg::DATA_W-1:0]     pwdata_i,
  output logic      [memcopy_pkg::DATA_W-1:0]     prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  output logic                                    intr_o
);

  // Regs to engine
  logic                            start;
  logic [memcopy_pkg::WADDR_W-1:0] src;
  logic [memcopy_pkg::WADDR_W-1:0] dst;
  logic [memcopy_pkg::SIZE_W-1:0]  size;
  logic                            busy;
  logic                            done;

  // Memory window
  logic                            win_req;
  logic                            win_we;
  logic [memcopy_pkg::WADDR_W-1:0] win_addr;
  logic [memcopy_pkg::DATA_W-1:0]  win_wdata;
  logic                            win_ack;
  logic [memcopy_pkg::DATA_W-1:0]  win_rdata;

  // Engine to memory
  logic                            mem_req;
  logic                            mem_we;
  logic [memcopy_pkg::WADDR_W-1:0] mem_addr;
  logic [memcopy_pkg::DATA_W-1:0]  mem_wdata;
  logic                            mem_gnt;
  logic [memcopy_pkg::DATA_W-1:0]  mem_rdata;
  logic                            mem_rvalid;

  memcopy_regs u_regs (
    .clk_i, .arst_n_i,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .busy_i(busy), .done_i(done),
    .win_ack_i(win_ack), .win_rdata_i(win_rdata),
    .start_o(start), .src_o(src), .dst_o(dst), .size_o(size),
    .win_req_o(win_req), .win_we_o(win_we), .win_addr_o(win_addr),
    .win_wdata_o(win_wdata),
    .intr_o
  );

  memcopy_engine u_engine (
    .clk_i, .arst_n_i,
    .start_i(start), .src_i(src), .dst_i(dst), .size_i(size),
    .busy_o(busy), .done_o(done),
    .win_req_i(win_req), .win_we_i(win_we), .win_addr_i(win_addr),
    .win_wdata_i(win_wdata), .win_ack_o(win_ack), .win_rdata_o(win_rdata),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_gnt_i(mem_gnt), .mem_rdata_i(mem_rdata),
    .mem_rvalid_i(mem_rvalid)
  );

  slow_memory u_mem (
    .clk_i, .arst_n_i,
    .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
    .gnt_o(mem_gnt), .rdata_o(mem_rdata), .rvalid_o(mem_rvalid)
  );

endmodule

`default_nettype wire

// ==== sim/memcopy_properties.sv ====
/*
 * Concurrent checks on the APB and memory handshakes of the subsystem
 */
`default_nettype none

module memcopy_properties (
  input wire logic                               clk_i,
  input wire logic                               arst_n_i,
  input wire logic                               psel_i,
  input wire logic                               penable_i,
  input wire logic                               pwrite_i,
  input wire logic [memcopy_pkg::APB_ADDR_W-1:0] paddr_i,
  input wire logic [memcopy_pkg::DATA_W-1:0]     pwdata_i,
  input wire logic                               pready_i,
  input wire logic                               intr_i,
  input wire logic                               mem_req_i,
  input wire logic                               mem_we_i,
  input wire logic [memcopy_pkg::WADDR_W-1:0]    mem_addr_i,
  input wire logic [memcopy_pkg::DATA_W-1:0]     mem_wdata_i,
  input wire logic                               mem_gnt_i,
  input wire logic                               mem_rvalid_i
);

  // APB master holds the transfer until pready
  apb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    psel_i && penable_i && !pready_i |=>
      psel_i && penable_i && $stable({pwrite_i, paddr_i, pwdata_i}))
    else $error("APB transfer changed while pready was low");

  mem_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable({mem_we_i, mem_addr_i, mem_wdata_i}))
    else $error("memory request dropped or changed before grant");

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_i && mem_gnt_i && !mem_we_i |=> mem_rvalid_i)
    else $error("no rvalid one cycle after a read grant");

  rvalid_only_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_rvalid_i |-> $past(mem_req_i && mem_gnt_i && !mem_we_i))
    else $error("rvalid without a read grant in the previous cycle");

  intr_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !intr_i)
    else $error("interrupt high during reset");

endmodule

bind memcopy_subsystem memcopy_properties u_props (
  .clk_i, .arst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
  .pready_i(pready_o), .intr_i(intr_o),
  .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
  .mem_wdata_i(mem_wdata), .mem_gnt_i(mem_gnt), .mem_rvalid_i(mem_rvalid)
);

`default_nettype wire

// ==== sim/tb_memcopy.sv ====
/*
 * Testbench for the memory-copy subsystem with an APB driver fed from
 * the stimulus file, result checks and a cycle timeout
 */
`default_nettype none

module tb_memcopy;

  localparam int CYCLES_PER_OP = 600;

  logic                               clk_i = 1'b1;
  logic                               arst_n_i;
  logic                               psel_i;
  logic                               penable_i;
  logic                               pwrite_i;
  logic [memcopy_pkg::APB_ADDR_W-1:0] paddr_i;
  logic [memcopy_pkg::DATA_W-1:0]     pwdata_i;
  logic [memcopy_pkg::DATA_W-1:0]     prdata_o;
  logic                               pready_o;
  logic                               pslverr_o;
  logic                               intr_o;

  // One entry per stimulus line
  logic [1:0]                         op_q[$];
  logic [memcopy_pkg::APB_ADDR_W-1:0] addr_q[$];
  logic [memcopy_pkg::DATA_W-1:0]     data_q[$];
  logic [memcopy_pkg::DATA_W-1:0]     exp_q[$];
  logic                               err_q[$];
  logic [31:0]                        lfsr = 32'h692d;
  int                                 cycles = 0;
  int                                 limit = 0;

  memcopy_subsystem UUT (.*);

  always #20 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      report_failure($sformatf("ERROR: timeout, no progress after %0d cycles", cycles));
    end
  end

  function automatic string addr_name(input logic [memcopy_pkg::APB_ADDR_W-1:0] a);
    if (a[memcopy_pkg::WIN_BIT]) begin
      return $sformatf("window word %0d", a[memcopy_pkg::WIN_BIT-1 -: memcopy_pkg::WADDR_W]);
    end
    case (a)
      memcopy_pkg::REG_SRC:    return "SRC";
      memcopy_pkg::REG_DST:    return "DST";
      memcopy_pkg::REG_SIZE:   return "SIZE";
      memcopy_pkg::REG_STATUS: return "STATUS";
      default:                 return $sformatf("offset 0x%03h", a);
    endcase
  endfunction

  task automatic check_data(input logic [memcopy_pkg::DATA_W-1:0] got,
                            input logic [memcopy_pkg::DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s read 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: %s pslverr %0b, expected %0b",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_intr(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t: intr_o %0b, expected %0b",
                               $time, got, exp));
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic idle_gap();
    logic [1:0] gap;
    lfsr = lfsr_next(lfsr);
    gap[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    gap[1] = lfsr[0];
    repeat (gap) @(negedge clk_i);
  endtask

  // Setup and access phase with the result sampled at the completing edge
  task automatic apb_xfer(input logic wr, input logic [memcopy_pkg::APB_ADDR_W-1:0] addr,
                          input logic [memcopy_pkg::DATA_W-1:0] wdata,
                          output logic [memcopy_pkg::DATA_W-1:0] rdata, output logic err);
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    @(posedge clk_i);
    while (!pready_o) begin
      @(posedge clk_i);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  initial begin
    int                                 fd;
    int                                 n;
    string                              line;
    logic [1:0]                         op;
    logic [memcopy_pkg::APB_ADDR_W-1:0] addr;
    logic [memcopy_pkg::DATA_W-1:0]     data;
    logic [memcopy_pkg::DATA_W-1:0]     exp;
    logic [memcopy_pkg::DATA_W-1:0]     rdata;
    logic                               err;
    logic                               got_err;

    arst_n_i  = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    fd = $fopen("sim/memcopy_stim.txt", "r");
    if (fd == 0) begin
      report_failure("ERROR: cannot open sim/memcopy_stim.txt");
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h", op, addr, data, exp, err);
        if (n != 5) begin
          report_failure({"ERROR: malformed stimulus line: ", line});
        end
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(exp);
        err_q.push_back(err);
      end
    end
    $fclose(fd);
    limit = op_q.size() * CYCLES_PER_OP;

    @(negedge clk_i);
    arst_n_i = 1'b0;
    repeat (8) @(negedge clk_i);
    arst_n_i = 1'b1;

    foreach (op_q[i]) begin
      idle_gap();
      case (op_q[i])
        2'd0: begin
          apb_xfer(1'b1, addr_q[i], data_q[i], rdata, got_err);
          check_err(got_err, err_q[i], addr_name(addr_q[i]));
        end
        2'd1: begin
          apb_xfer(1'b0, addr_q[i], '0, rdata, got_err);
          check_err(got_err, err_q[i], addr_name(addr_q[i]));
          // Data of a refused read is undefined
          if (!err_q[i]) begin
            check_data(rdata, exp_q[i], addr_name(addr_q[i]));
          end
        end
        2'd2: begin
          // Wait for the end of the copy
          @(posedge clk_i);
          while (intr_o !== exp_q[i][memcopy_pkg::STATUS_DONE_BIT]) begin
            @(posedge clk_i);
          end
        end
        default: begin
          @(posedge clk_i);
          check_intr(intr_o, exp_q[i][memcopy_pkg::STATUS_DONE_BIT]);
        end
      endcase
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/memcopy_stim.txt ====
# op addr data expected err, all hex; op 0 write, 1 read, 2 wait for intr, 3 sample intr
# Read data is compared only when err is 0; ops 2 and 3 compare intr with expected bit 1
0 200 11111111 00000000 0
0 204 22222222 00000000 0
0 004 00000001 00000000 0
0 008 00000002 00000000 0
2 000 00000000 00000002 0
1 00C 00000000 00000002 0
1 208 00000000 11111111 0
0 3FC 7F7F7F7F 00000000 0
0 000 0000007F 00000000 0
0 008 00000003 00000000 0
2 000 00000000 00000002 0
1 204 00000000 7F7F7F7F 0
0 010 00000000 00000000 1
0 000 00000040 00000000 0
0 008 00000020 00000000 0
1 00C 00000000 00000003 0
0 000 00000055 00000000 1
1 200 00000000 00000000 1
1 000 00000000 00000040 0
2 000 00000000 00000002 0
1 00C 00000000 00000002 0
0 008 00000000 00000000 0
2 000 00000000 00000002 0
1 00C 00000000 00000002 0
3 000 00000000 00000000 0
1 200 00000000 11111111 0

// ==== files.f ====
hdl/memcopy_pkg.sv
hdl/memcopy_regs.sv
hdl/memcopy_engine.sv
hdl/slow_memory.sv
hdl/memcopy_subsystem.sv
sim/memcopy_properties.sv
sim/tb_memcopy.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then judge the log
rm -f sim.log &&
verilator --binary --assert --top-module tb_memcopy -f files.f -o tb_memcopy > build.log 2>&1 &&
./obj_dir/tb_memcopy > sim.log 2>&1
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Build failed or simulation did not finish"; exit 1; }
echo "Simulation passed"
